//--- gpu_mem.f
+incdir+source
source/gpu_mem_pkg.sv
source/block_select.sv
source/cache_latency_emulator.sv
source/coalesce_stage.sv
source/mem_stage_top.sv
verification/clock_gen.sv
verification/mem_stage_tb.sv

//--- source/block_select.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpu_mem_defs.svh"

module block_select
(
	input  wire                        clk,
	input  wire                        resetb,
	input  wire                        req_valid_i,
	input  gpu_mem_pkg::warp_req_t     warp_req_i,
	input  wire                        lookup_done_i,
	input  wire                        hit_i,
	input  wire                        miss_wait_i,
	output gpu_mem_pkg::block_access_t access_o,
	output logic                       access_valid_o,
	output logic                       busy_o
);

	gpu_mem_pkg::sel_state_e state_q;
	gpu_mem_pkg::sel_state_e state_d;
	gpu_mem_pkg::warp_req_t  warp_q;
	logic [`GM_LANES-1:0]    pending_q;
	logic [`GM_LANES-1:0]    pending_d;
	logic [`GM_LANES-1:0]    match;
	logic [`GM_BLOCK_W-1:0]  sel_block;
	logic                    load;

	// Block of the lowest pending lane, and every pending lane sharing it.
	always_comb
	begin
		sel_block = '0;
		for (int i = `GM_LANES-1; i >= 0; i--)
		begin
			if (pending_q[i])
				sel_block = warp_q.eff_addr[i][`GM_WORD_W-1:`GM_WORD_W-`GM_BLOCK_W];
		end
		for (int i = 0; i < `GM_LANES; i++)
		begin
			match[i] = pending_q[i] &&
				(warp_q.eff_addr[i][`GM_WORD_W-1:`GM_WORD_W-`GM_BLOCK_W] == sel_block);
		end
	end

	always_comb
	begin
		state_d   = state_q;
		pending_d = pending_q;
		load      = 1'b0;
		case (state_q)
			gpu_mem_pkg::SEL_IDLE:
			begin
				if (req_valid_i && (|warp_req_i.pam))
				begin
					load      = 1'b1;
					pending_d = warp_req_i.pam;
					state_d   = gpu_mem_pkg::SEL_ISSUE;
				end
			end
			gpu_mem_pkg::SEL_ISSUE:
				state_d = gpu_mem_pkg::SEL_WAIT;
			gpu_mem_pkg::SEL_WAIT:
			begin
				if (lookup_done_i)
				begin
					// A miss keeps the lanes and holds here for the fill.
					if (hit_i)
					begin
						pending_d = pending_q & ~match;
						state_d   = (|pending_d) ? gpu_mem_pkg::SEL_ISSUE : gpu_mem_pkg::SEL_IDLE;
					end
				end
				else if (!miss_wait_i)
					state_d = gpu_mem_pkg::SEL_ISSUE;
			end
			default:
				state_d = gpu_mem_pkg::SEL_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
		begin
			state_q   <= gpu_mem_pkg::SEL_IDLE;
			pending_q <= '0;
		end
		else
		begin
			state_q   <= state_d;
			pending_q <= pending_d;
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
			warp_q <= warp_req_i;
	end

	always_comb
	begin
		access_o.op          = warp_q.op;
		access_o.shared      = warp_q.shared;
		access_o.warp_id     = warp_q.warp_id;
		access_o.scb_id      = warp_q.scb_id;
		access_o.reg_addr    = warp_q.reg_addr;
		access_o.pam_pending = pending_q;
		access_o.block_addr  = sel_block;
		access_o.eff_addr    = warp_q.eff_addr;
		access_o.write_data  = warp_q.write_data;
	end

	assign access_valid_o = (state_q == gpu_mem_pkg::SEL_ISSUE);
	assign busy_o         = (state_q != gpu_mem_pkg::SEL_IDLE);

endmodule

`default_nettype wire

//--- source/cache_latency_emulator.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpu_mem_defs.svh"

module cache_latency_emulator
(
	input  wire                        clk,
	input  wire                        resetb,
	input  gpu_mem_pkg::block_access_t access_i,
	input  wire                        access_valid_i,
	input  wire                        lat_write_i,
	input  wire  [`GM_LAT_W-1:0]       lat_value_i,
	input  wire                        fill_valid_i,
	input  wire  [`GM_BLOCK_W-1:0]     fill_addr_i,
	output logic                       hit_o,
	output logic                       lookup_done_o,
	output logic                       miss_o,
	output logic                       miss_wait_o,
	output logic [`GM_BLOCK_W-1:0]     miss_addr_o,
	output logic [`GM_LAT_W-1:0]       miss_latency_o
);

	// Full block address is kept as the tag.
	logic [`GM_BLOCK_W-1:0]                  tag_mem [`GM_CACHE_LINES];
	logic [`GM_CACHE_LINES-1:0]              valid_q;
	logic [$clog2(`GM_CACHE_LINES)-1:0]      look_idx;
	logic [$clog2(`GM_CACHE_LINES)-1:0]      fill_idx;
	logic [`GM_LAT_W-1:0]                    lat_q;
	logic                                    tag_hit;
	logic                                    miss_now;
	logic                                    fill_match;

	assign look_idx = access_i.block_addr[$clog2(`GM_CACHE_LINES)-1:0];
	assign fill_idx = fill_addr_i[$clog2(`GM_CACHE_LINES)-1:0];

	// Shared memory has no tags and always proceeds.
	assign tag_hit  = access_i.shared ||
		(valid_q[look_idx] && (tag_mem[look_idx] == access_i.block_addr));
	assign miss_now = access_valid_i && !tag_hit;

	assign fill_match = fill_valid_i && miss_wait_o && (fill_addr_i == miss_addr_o);

	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
		begin
			hit_o         <= 1'b0;
			lookup_done_o <= 1'b0;
			miss_o        <= 1'b0;
		end
		else
		begin
			hit_o         <= access_valid_i && tag_hit;
			lookup_done_o <= access_valid_i;
			miss_o        <= miss_now;
		end
	end

	// Only one miss is outstanding at a time.
	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
			miss_wait_o <= 1'b0;
		else if (miss_now)
			miss_wait_o <= 1'b1;
		else if (fill_match)
			miss_wait_o <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (miss_now)
			miss_addr_o <= access_i.block_addr;
	end

	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
			valid_q <= '0;
		else if (fill_valid_i)
			valid_q[fill_idx] <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (fill_valid_i)
			tag_mem[fill_idx] <= fill_addr_i;
	end

	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
			lat_q <= '0;
		else if (lat_write_i)
			lat_q <= lat_value_i;
	end

	// Downstream memory uses this to schedule the fill.
	assign miss_latency_o = lat_q;

endmodule

`default_nettype wire

//--- source/coalesce_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpu_mem_defs.svh"

module coalesce_stage
(
	input  wire                        clk,
	input  wire                        resetb,
	input  gpu_mem_pkg::block_access_t access_i,
	input  wire                        access_valid_i,
	input  wire                        lookup_done_i,
	input  wire                        hit_i,
	output gpu_mem_pkg::mem_result_t   result_o,
	output logic                       result_valid_o
);

	gpu_mem_pkg::block_access_t                   acc_q;
	gpu_mem_pkg::mem_op_e                         op_q;
	logic [`GM_LANES-1:0]                         thread_mask;
	logic [`GM_LANES-1:0]                         write_mask;
	logic [`GM_LANES-1:0][`GM_WORD_SEL_W-1:0]     word_offset;
	logic [`GM_LANES-1:0][`GM_WORD_W-1:0]         write_data;
	logic [`GM_LANES-1:0][`GM_BLOCK_W-1:0]        lane_block;

	// Operation is the only control field.
	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
			op_q <= gpu_mem_pkg::MEM_NONE;
		else if (access_valid_i)
			op_q <= access_i.op;
	end

	always_ff @(posedge clk)
	begin
		if (access_valid_i)
			acc_q <= access_i;
	end

	// Per lane block address and word within the block.
	always_comb
	begin
		for (int i = 0; i < `GM_LANES; i++)
		begin
			lane_block[i]  = acc_q.eff_addr[i][`GM_WORD_W-1:`GM_WORD_W-`GM_BLOCK_W];
			word_offset[i] = acc_q.eff_addr[i][`GM_WORD_SEL_W+1:2];
		end
	end

	// Thread mask.
	always_comb
	begin
		for (int i = 0; i < `GM_LANES; i++)
			thread_mask[i] = acc_q.pam_pending[i] && (lane_block[i] == acc_q.block_addr);
	end

	// Ascending scan so the highest lane on a word wins.
	always_comb
	begin
		for (int j = 0; j < `GM_LANES; j++)
		begin
			write_mask[j] = 1'b0;
			write_data[j] = '0;
			for (int i = 0; i < `GM_LANES; i++)
			begin
				if (thread_mask[i] && (word_offset[i] == `GM_WORD_SEL_W'(j)))
				begin
					write_mask[j] = 1'b1;
					write_data[j] = acc_q.write_data[i];
				end
			end
		end
	end

	assign result_valid_o = lookup_done_i && hit_i;

	always_comb
	begin
		result_o.mem_read    = result_valid_o && (op_q == gpu_mem_pkg::MEM_READ);
		result_o.mem_write   = result_valid_o && (op_q == gpu_mem_pkg::MEM_WRITE);
		result_o.block_addr  = acc_q.block_addr;
		result_o.warp_id     = acc_q.warp_id;
		result_o.scb_id      = acc_q.scb_id;
		result_o.reg_addr    = acc_q.reg_addr;
		result_o.thread_mask = thread_mask;
		result_o.write_mask  = write_mask;
		result_o.word_offset = word_offset;
		result_o.write_data  = write_data;
	end

endmodule

`default_nettype wire

//--- source/gpu_mem_defs.svh
`ifndef GPU_MEM_DEFS_SVH
`define GPU_MEM_DEFS_SVH

// Threads per warp, also the words per 32-byte block.
`define GM_LANES 8

`define GM_WORD_W 32
`define GM_BLOCK_W 27
`define GM_WORD_SEL_W 3

// Direct-mapped tag store.
`define GM_CACHE_LINES 32
`define GM_LAT_W 5

`define GM_WARP_W 3
`define GM_SCB_W 2
`define GM_REG_W 5

`endif

//--- source/gpu_mem_pkg.sv
`default_nettype none

`include "gpu_mem_defs.svh"

package gpu_mem_pkg;

	typedef enum logic [1:0] {
		MEM_NONE  = 2'd0,
		MEM_READ  = 2'd1,
		MEM_WRITE = 2'd2
	} mem_op_e;

	typedef enum logic [1:0] {
		SEL_IDLE  = 2'd0,
		SEL_ISSUE = 2'd1,
		SEL_WAIT  = 2'd2
	} sel_state_e;

	// One warp instruction as it enters the stage.
	typedef struct packed {
		mem_op_e                                 op;
		logic                                    shared;
		logic [`GM_WARP_W-1:0]                   warp_id;
		logic [`GM_SCB_W-1:0]                    scb_id;
		logic [`GM_REG_W-1:0]                    reg_addr;
		logic [`GM_LANES-1:0]                    pam;
		logic [`GM_LANES-1:0][`GM_WORD_W-1:0]    eff_addr;
		logic [`GM_LANES-1:0][`GM_WORD_W-1:0]    write_data;
	} warp_req_t;

	typedef struct packed {
		mem_op_e                                 op;
		logic                                    shared;
		logic [`GM_WARP_W-1:0]                   warp_id;
		logic [`GM_SCB_W-1:0]                    scb_id;
		logic [`GM_REG_W-1:0]                    reg_addr;
		logic [`GM_LANES-1:0]                    pam_pending;
		logic [`GM_BLOCK_W-1:0]                  block_addr;
		logic [`GM_LANES-1:0][`GM_WORD_W-1:0]    eff_addr;
		logic [`GM_LANES-1:0][`GM_WORD_W-1:0]    write_data;
	} block_access_t;

	typedef struct packed {
		logic                                    mem_read;
		logic                                    mem_write;
		logic [`GM_BLOCK_W-1:0]                  block_addr;
		logic [`GM_WARP_W-1:0]                   warp_id;
		logic [`GM_SCB_W-1:0]                    scb_id;
		logic [`GM_REG_W-1:0]                    reg_addr;
		logic [`GM_LANES-1:0]                    thread_mask;
		logic [`GM_LANES-1:0]                    write_mask;
		logic [`GM_LANES-1:0][`GM_WORD_SEL_W-1:0] word_offset;
		logic [`GM_LANES-1:0][`GM_WORD_W-1:0]    write_data;
	} mem_result_t;

endpackage

`default_nettype wire

//--- source/mem_stage_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpu_mem_defs.svh"

module mem_stage_top
(
	input  wire                      clk,
	input  wire                      resetb,
	input  wire                      req_valid_i,
	input  gpu_mem_pkg::warp_req_t   warp_req_i,
	input  wire                      lat_write_i,
	input  wire  [`GM_LAT_W-1:0]     lat_value_i,
	input  wire                      fill_valid_i,
	input  wire  [`GM_BLOCK_W-1:0]   fill_addr_i,
	output gpu_mem_pkg::mem_result_t result_o,
	output logic                     result_valid_o,
	output logic                     miss_o,
	output logic [`GM_BLOCK_W-1:0]   miss_addr_o,
	output logic [`GM_LAT_W-1:0]     miss_latency_o,
	output logic                     busy_o
);

	gpu_mem_pkg::block_access_t access;
	logic                       access_valid;
	logic                       hit;
	logic                       miss_wait;
	logic                       lookup_done;

	block_select u_block_select (
		.clk            (clk),
		.resetb         (resetb),
		.req_valid_i    (req_valid_i),
		.warp_req_i     (warp_req_i),
		.lookup_done_i  (lookup_done),
		.hit_i          (hit),
		.miss_wait_i    (miss_wait),
		.access_o       (access),
		.access_valid_o (access_valid),
		.busy_o         (busy_o)
	);

	cache_latency_emulator u_cache (
		.clk            (clk),
		.resetb         (resetb),
		.access_i       (access),
		.access_valid_i (access_valid),
		.lat_write_i    (lat_write_i),
		.lat_value_i    (lat_value_i),
		.fill_valid_i   (fill_valid_i),
		.fill_addr_i    (fill_addr_i),
		.hit_o          (hit),
		.lookup_done_o  (lookup_done),
		.miss_o         (miss_o),
		.miss_wait_o    (miss_wait),
		.miss_addr_o    (miss_addr_o),
		.miss_latency_o (miss_latency_o)
	);

	coalesce_stage u_coalesce (
		.clk            (clk),
		.resetb         (resetb),
		.access_i       (access),
		.access_valid_i (access_valid),
		.lookup_done_i  (lookup_done),
		.hit_i          (hit),
		.result_o       (result_o),
		.result_valid_o (result_valid_o)
	);

endmodule

`default_nettype wire

//--- verification/clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clock_gen
(
	output logic clk,
	output logic resetb
);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	// Released on a falling edge after four rising edges.
	initial
	begin
		resetb = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		resetb = 1'b1;
	end

endmodule

`default_nettype wire

//--- verification/mem_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpu_mem_defs.svh"

module mem_stage_tb;

	wire                       clk;
	wire                       resetb;
	logic                      req_valid_i;
	gpu_mem_pkg::warp_req_t    warp_req_i;
	logic                      lat_write_i;
	logic [`GM_LAT_W-1:0]      lat_value_i;
	logic                      fill_valid_i;
	logic [`GM_BLOCK_W-1:0]    fill_addr_i;
	gpu_mem_pkg::mem_result_t  result_o;
	logic                      result_valid_o;
	logic                      miss_o;
	logic [`GM_BLOCK_W-1:0]    miss_addr_o;
	logic [`GM_LAT_W-1:0]      miss_latency_o;
	logic                      busy_o;

	gpu_mem_pkg::mem_result_t  exp_res [`GM_LANES];
	gpu_mem_pkg::mem_result_t  got_res [`GM_LANES];
	int                        exp_n;
	int                        got_n;
	int                        miss_n;
	int                        first_res_cycle;
	int                        late_busy;
	logic [`GM_LAT_W-1:0]      seen_lat;
	logic [`GM_LANES-1:0]      seen_mask_or;
	logic [31:0]               rng;
	int                        value_errs;
	int                        other_errs;

	clock_gen u_clock_gen (
		.clk    (clk),
		.resetb (resetb)
	);

	mem_stage_top uut (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic draw(output logic [31:0] v);
		rng = xorshift32(rng);
		v = rng;
	endtask

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			value_errs++;
			$display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	// Blocks come out in order of the lowest pending lane; the highest lane wins a word.
	task automatic build_expected(input gpu_mem_pkg::warp_req_t req);
		gpu_mem_pkg::mem_result_t r;
		logic [`GM_LANES-1:0]     pend;
		logic [`GM_BLOCK_W-1:0]   blk;
		int                       first;
		int                       w;
		pend = req.pam;
		exp_n = 0;
		while (pend != 0)
		begin
			first = 0;
			while (!pend[first])
				first++;
			blk = req.eff_addr[first] >> 5;
			r = '0;
			r.mem_read = (req.op == gpu_mem_pkg::MEM_READ);
			r.mem_write = (req.op == gpu_mem_pkg::MEM_WRITE);
			r.block_addr = blk;
			r.warp_id = req.warp_id;
			r.scb_id = req.scb_id;
			r.reg_addr = req.reg_addr;
			for (int i = 0; i < `GM_LANES; i++)
			begin
				w = (req.eff_addr[i] >> 2) & 7;
				r.word_offset[i] = w;
				if (pend[i] && ((req.eff_addr[i] >> 5) == blk))
				begin
					r.thread_mask[i] = 1'b1;
					r.write_mask[w] = 1'b1;
					r.write_data[w] = req.write_data[i];
				end
			end
			pend = pend & ~r.thread_mask;
			exp_res[exp_n] = r;
			exp_n++;
		end
	endtask

	task automatic compare_result(input logic fill_pend);
		gpu_mem_pkg::mem_result_t e;
		if (fill_pend)
		begin
			other_errs++;
			$display("result produced while a miss was still outstanding at %0t", $time);
		end
		if (got_n >= exp_n)
		begin
			other_errs++;
			$display("unexpected extra result for block 0x%0h", result_o.block_addr);
			return;
		end
		e = exp_res[got_n];
		check("mem_read", result_o.mem_read, e.mem_read);
		check("mem_write", result_o.mem_write, e.mem_write);
		check("block_addr", result_o.block_addr, e.block_addr);
		check("warp_id", result_o.warp_id, e.warp_id);
		check("scb_id", result_o.scb_id, e.scb_id);
		check("reg_addr", result_o.reg_addr, e.reg_addr);
		check("thread_mask", result_o.thread_mask, e.thread_mask);
		check("write_mask", result_o.write_mask, e.write_mask);
		check("word_offset", result_o.word_offset, e.word_offset);
		for (int w = 0; w < `GM_LANES; w++)
		begin
			if (e.write_mask[w])
				check("write_data", result_o.write_data[w], e.write_data[w]);
		end
		check("thread_mask_overlap", seen_mask_or & result_o.thread_mask, 0);
		seen_mask_or |= result_o.thread_mask;
		got_res[got_n] = result_o;
		got_n++;
	endtask

	task automatic wait_idle();
		int n;
		for (n = 0; n < 50; n++)
		begin
			@(negedge clk);
			if (!busy_o)
				break;
		end
		if (n == 50)
		begin
			other_errs++;
			$display("timeout: stage stayed busy before a new request");
		end
	endtask

	// Sends one warp, answers misses with a fill after the reported latency.
	task automatic run_warp(input gpu_mem_pkg::warp_req_t req);
		int   cycles;
		int   fill_cnt;
		logic fill_pend;
		build_expected(req);
		got_n = 0;
		miss_n = 0;
		first_res_cycle = -1;
		late_busy = 0;
		seen_mask_or = '0;
		fill_pend = 1'b0;
		fill_cnt = 0;
		cycles = 0;
		wait_idle();
		warp_req_i = req;
		req_valid_i = 1'b1;
		do
		begin
			@(negedge clk);
			req_valid_i = 1'b0;
			fill_valid_i = 1'b0;
			if (result_valid_o)
			begin
				if (got_n == 0)
					first_res_cycle = cycles + 1;
				compare_result(fill_pend || miss_o);
			end
			else
			begin
				check("mem_read", result_o.mem_read, 0);
				check("mem_write", result_o.mem_write, 0);
				if (got_n == exp_n && busy_o)
					late_busy++;
			end
			if (miss_o)
			begin
				miss_n++;
				seen_lat = miss_latency_o;
				if (got_n < exp_n)
					check("miss_addr_o", miss_addr_o, exp_res[got_n].block_addr);
				fill_pend = 1'b1;
				fill_cnt = miss_latency_o;
			end
			if (fill_pend)
			begin
				if (fill_cnt == 0)
				begin
					fill_valid_i = 1'b1;
					fill_addr_i = miss_addr_o;
					fill_pend = 1'b0;
				end
				else
					fill_cnt--;
			end
			cycles++;
		end
		while (busy_o && cycles < 300);
		if (busy_o)
		begin
			other_errs++;
			$display("timeout: warp still busy after 300 cycles");
		end
		check("result_count", got_n, exp_n);
	endtask

	task automatic make_req(input gpu_mem_pkg::mem_op_e op, input logic shared,
		input logic [`GM_LANES-1:0] pam, output gpu_mem_pkg::warp_req_t req);
		logic [31:0] v;
		req = '0;
		req.op = op;
		req.shared = shared;
		req.pam = pam;
		draw(v);
		req.warp_id = v[`GM_WARP_W-1:0];
		req.scb_id = v[8+`GM_SCB_W-1:8];
		req.reg_addr = v[16+`GM_REG_W-1:16];
		for (int i = 0; i < `GM_LANES; i++)
		begin
			draw(v);
			req.write_data[i] = v;
			draw(v);
			req.eff_addr[i] = v;
		end
	endtask

	task automatic test_reset();
		int n;
		n = 0;
		while (resetb !== 1'b1 && n < 20)
		begin
			@(negedge clk);
			n++;
		end
		if (resetb !== 1'b1)
		begin
			other_errs++;
			$display("timeout: reset was never released");
		end
		@(negedge clk);
		check("busy_o", busy_o, 0);
		check("result_valid_o", result_valid_o, 0);
		check("miss_o", miss_o, 0);
		check("miss_latency_o", miss_latency_o, 0);
	endtask

	task automatic test_shared_read();
		gpu_mem_pkg::warp_req_t req;
		logic [31:0]            base;
		make_req(gpu_mem_pkg::MEM_READ, 1'b1, 8'hff, req);
		base = req.eff_addr[0] & 32'hffff_ffe0;
		for (int i = 0; i < `GM_LANES; i++)
			req.eff_addr[i] = base | ((7 - i) << 2);
		run_warp(req);
		check("result_count", got_n, 1);
		check("miss_count", miss_n, 0);
		check("thread_mask", seen_mask_or, req.pam);
		// A hit returns two cycles after the request.
		check("first_result_cycle", first_res_cycle, 2);
	endtask

	task automatic test_miss_replay();
		gpu_mem_pkg::warp_req_t req;
		@(negedge clk);
		lat_write_i = 1'b1;
		lat_value_i = 5'd7;
		@(negedge clk);
		lat_write_i = 1'b0;
		make_req(gpu_mem_pkg::MEM_READ, 1'b0, 8'h3c, req);
		for (int i = 0; i < `GM_LANES; i++)
			req.eff_addr[i] = 32'h4000_1200 | (i << 2);
		run_warp(req);
		check("miss_count", miss_n, 1);
		check("miss_latency_o", seen_lat, 7);
		check("result_count", got_n, 1);
		// Same block again is now in the tag store.
		run_warp(req);
		check("miss_count", miss_n, 0);
		check("result_count", got_n, 1);
	endtask

	task automatic test_divergent_write();
		gpu_mem_pkg::warp_req_t req;
		make_req(gpu_mem_pkg::MEM_WRITE, 1'b1, 8'hff, req);
		req.eff_addr[0] = 32'h1000_0044;
		req.eff_addr[1] = 32'h2000_0100;
		req.eff_addr[2] = 32'h1000_004c;
		req.eff_addr[3] = 32'h0000_3ff4;
		req.eff_addr[4] = 32'h2000_0108;
		req.eff_addr[5] = 32'h1000_0044;
		req.eff_addr[6] = 32'h0000_3fe0;
		req.eff_addr[7] = 32'h2000_011c;
		run_warp(req);
		check("result_count", got_n, 3);
		check("thread_mask", seen_mask_or, req.pam);
		check("shared_word_data", got_res[0].write_data[1], req.write_data[5]);
	endtask

	task automatic test_inactive_lanes();
		gpu_mem_pkg::warp_req_t req;
		logic [31:0]            v;
		logic [31:0]            base;
		for (int k = 0; k < 4; k++)
		begin
			draw(v);
			make_req(gpu_mem_pkg::MEM_READ, 1'b0, (v[7:0] & 8'hee) | 8'h20, req);
			base = req.eff_addr[0] & 32'hffff_ff00;
			for (int i = 0; i < `GM_LANES; i++)
				req.eff_addr[i] = base | (req.eff_addr[i] & 32'h0000_00fc);
			run_warp(req);
			check("inactive_lanes", seen_mask_or & ~req.pam, 0);
			// Busy drops in the cycle after the last result.
			check("busy_late_cycles", late_busy, 0);
		end
	endtask

	initial
	begin
		rng = 32'h2c9b;
		value_errs = 0;
		other_errs = 0;
		req_valid_i = 1'b0;
		warp_req_i = '0;
		lat_write_i = 1'b0;
		lat_value_i = '0;
		fill_valid_i = 1'b0;
		fill_addr_i = '0;
		test_reset();
		test_shared_read();
		test_miss_replay();
		test_divergent_write();
		test_inactive_lanes();
		$display("value errors: %0d, other errors: %0d", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
